// ==== common/core_pkg.sv ====
// Control core shared definitions

package core_pkg;

   //////////////////////////////
   // Bus widths

   localparam int WB_DW  = 16;   // Wishbone data
   localparam int WB_AW  = 11;   // Wishbone address
   localparam int SET_AW = 8;    // Settings bus address

   typedef logic [WB_DW-1:0]  wb_data_t;
   typedef logic [WB_AW-1:0]  wb_addr_t;
   typedef logic [SET_AW-1:0] set_addr_t;
   typedef logic [31:0]       set_data_t;
   typedef logic [63:0]       vita_time_t;

   //////////////////////////////
   // Slave decode on address bits 10:7

   localparam logic [3:0] SLAVE_MISC     = 4'd0;
   localparam logic [3:0] SLAVE_READBACK = 4'd7;
   // Slave numbers 8 to 15 all land on the settings bus

   //////////////////////////////
   // Settings register map

   localparam set_addr_t SR_TIME64     = 8'd42;   // Three regs for hi, lo and ctrl
   localparam set_addr_t SR_REG_TEST32 = 8'd60;   // 1 reg

   //////////////////////////////
   // Misc register indices

   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;   // Read/write
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;   // Read only
   localparam logic [6:0] REG_TEST      = 7'd8;   // Read/write

   localparam wb_data_t MISC_DEFAULT = 16'hBEEF;

   // Bumped whenever the register map changes
   localparam set_data_t COMPAT_NUM = {16'd10, 16'd2};   // Major, minor

endpackage

// ==== settings/settings_bus_16le.sv ====
// Settings bus sequencer

`timescale 1ns/10ps

module settings_bus_16le (
   input  logic                wb_clk,
   input  logic                wb_rst,
   input  core_pkg::wb_addr_t  wb_adr_i,
   input  core_pkg::wb_data_t  wb_dat_i,
   input  logic                wb_stb_i,
   input  logic                wb_we_i,
   output logic                wb_ack_o,
   output logic                set_stb_o,
   output core_pkg::set_addr_t set_addr_o,
   output core_pkg::set_data_t set_data_o
);
   import core_pkg::*;

   typedef enum logic {IDLE, HAVE_LOW} seq_state_t;

   seq_state_t state;
   wb_data_t   low_half;     // Held until the high half arrives
   logic       wr_low;
   logic       wr_high;
   logic       wr_commit;

   assign wb_ack_o  = wb_stb_i;                      // No wait states
   assign wr_low    = wb_stb_i & wb_we_i & ~wb_adr_i[1];
   assign wr_high   = wb_stb_i & wb_we_i & wb_adr_i[1];
   assign wr_commit = wr_high & (state == HAVE_LOW);

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         state     <= IDLE;
         set_stb_o <= 1'b0;
      end
      else
      begin
         set_stb_o <= wr_commit;                     // One cycle pulse
         if (wr_low)
            state <= HAVE_LOW;
         else if (wr_high)
            state <= IDLE;                           // Lone high half is dropped
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_low)
         low_half <= wb_dat_i;
      if (wr_commit)
      begin
         set_addr_o <= wb_adr_i[9:2];
         set_data_o <= {wb_dat_i, low_half};
      end
   end

endmodule

// ==== timing/vita_time_64.sv ====
// VITA 64-bit time counter

`timescale 1ns/10ps

module vita_time_64 #(
   parameter core_pkg::set_addr_t BASE = core_pkg::SR_TIME64
) (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  logic                 set_stb_i,
   input  core_pkg::set_addr_t  set_addr_i,
   input  core_pkg::set_data_t  set_data_i,
   input  logic                 pps_i,
   output core_pkg::vita_time_t vita_time_o,
   output core_pkg::vita_time_t vita_time_pps_o
);
   import core_pkg::*;

   localparam set_addr_t ADDR_HI   = BASE;
   localparam set_addr_t ADDR_LO   = BASE + 8'd1;
   localparam set_addr_t ADDR_CTRL = BASE + 8'd2;   // Bit 0 set loads now

   set_data_t pend_hi;
   set_data_t pend_lo;
   logic      armed;        // Load waits for next PPS
   logic      ctrl_wr;
   logic      load_now;
   logic      load_pps;
   logic      pps_meta;
   logic      pps_sync;
   logic      pps_del;
   logic      pps_edge;

   assign ctrl_wr  = set_stb_i & (set_addr_i == ADDR_CTRL);
   assign load_now = ctrl_wr & set_data_i[0];
   assign pps_edge = pps_sync & ~pps_del;
   assign load_pps = pps_edge & armed;

   // Pending time words
   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && (set_addr_i == ADDR_HI))
         pend_hi <= set_data_i;
      if (set_stb_i && (set_addr_i == ADDR_LO))
         pend_lo <= set_data_i;
   end

   //////////////////////////////
   // PPS synchronizer and edge detect

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_del  <= 1'b0;
      end
      else
      begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_del  <= pps_sync;
      end
   end

   //////////////////////////////
   // Counter, load and capture

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         armed           <= 1'b0;
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
      end
      else
      begin
         if (ctrl_wr)
            armed <= ~set_data_i[0];
         else if (pps_edge)
            armed <= 1'b0;                           // One shot

         if (load_now || load_pps)
            vita_time_o <= {pend_hi, pend_lo};
         else
            vita_time_o <= vita_time_o + 64'd1;

         if (pps_edge)
            vita_time_pps_o <= vita_time_o;          // Count seen on the edge
      end
   end

endmodule

// ==== design/misc_regs.sv ====
// Misc control and status registers

`timescale 1ns/10ps

module misc_regs #(
   parameter core_pkg::set_addr_t TEST_ADDR = core_pkg::SR_REG_TEST32
) (
   input  logic                wb_clk,
   input  logic                wb_rst,
   input  logic [6:0]          wb_adr_i,
   input  core_pkg::wb_data_t  wb_dat_i,
   input  logic                wb_stb_i,
   input  logic                wb_we_i,
   output core_pkg::wb_data_t  wb_dat_o,
   output logic                wb_ack_o,
   input  logic                set_stb_i,
   input  core_pkg::set_addr_t set_addr_i,
   input  core_pkg::set_data_t set_data_i,
   input  logic                cgen_st_status_i,
   input  logic                cgen_st_ld_i,
   input  logic                cgen_st_refmon_i,
   output logic                cgen_sync_b_o,
   output logic                cgen_ref_sel_o,
   output core_pkg::set_data_t reg_test32_o
);
   import core_pkg::*;

   wb_data_t reg_cgen_ctrl;
   wb_data_t reg_test;

   assign wb_ack_o = wb_stb_i;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_cgen_ctrl <= 16'd3;                     // Sync deasserted, ref 1
         reg_test      <= '0;
      end
      else if (wb_stb_i && wb_we_i)
      begin
         case (wb_adr_i)
            REG_CGEN_CTRL: reg_cgen_ctrl <= wb_dat_i;
            REG_TEST:      reg_test      <= wb_dat_i;
            default:       ;
         endcase
      end
   end

   // Persistent test setting for the host
   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && (set_addr_i == TEST_ADDR))
         reg_test32_o <= set_data_i;
   end

   always_comb
   begin
      case (wb_adr_i)
         REG_CGEN_CTRL: wb_dat_o = reg_cgen_ctrl;
         REG_CGEN_ST:
            wb_dat_o = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         REG_TEST:      wb_dat_o = reg_test;
         default:       wb_dat_o = MISC_DEFAULT;
      endcase
   end

   assign {cgen_sync_b_o, cgen_ref_sel_o} = reg_cgen_ctrl[1:0];

endmodule

// ==== design/readback_mux.sv ====
// Readback mux of 32-bit words

`timescale 1ns/10ps

module readback_mux (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  logic [5:1]           wb_adr_i,      // Word in 5:2, half in 1
   input  logic                 wb_stb_i,
   output core_pkg::wb_data_t   wb_dat_o,
   output logic                 wb_ack_o,
   input  core_pkg::vita_time_t vita_time_i,
   input  core_pkg::vita_time_t vita_time_pps_i,
   input  core_pkg::set_data_t  reg_test32_i
);
   import core_pkg::*;

   set_data_t sel_word;

   always_comb
   begin
      case (wb_adr_i[5:2])
         4'd0:    sel_word = vita_time_i[63:32];
         4'd1:    sel_word = vita_time_i[31:0];
         4'd2:    sel_word = vita_time_pps_i[63:32];
         4'd3:    sel_word = vita_time_pps_i[31:0];
         4'd4:    sel_word = reg_test32_i;
         4'd6:    sel_word = COMPAT_NUM;
         default: sel_word = '0;
      endcase
   end

   // Ack one cycle after strobe and dropped while the master releases
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         wb_ack_o <= 1'b0;
      else
         wb_ack_o <= wb_stb_i & ~wb_ack_o;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_stb_i)
         wb_dat_o <= wb_adr_i[1] ? sel_word[31:16] : sel_word[15:0];   // Low half first
   end

endmodule

// ==== design/core_top.sv ====
// Radio control core top

`timescale 1ns/10ps

module core_top #(
   parameter core_pkg::set_addr_t TIME_BASE = core_pkg::SR_TIME64,
   parameter core_pkg::set_addr_t TEST_ADDR = core_pkg::SR_REG_TEST32
) (
   input  logic               wb_clk,
   input  logic               wb_rst,
   input  core_pkg::wb_addr_t wb_adr_i,
   input  core_pkg::wb_data_t wb_dat_i,
   input  logic               wb_we_i,
   input  logic               wb_cyc_i,
   input  logic               wb_stb_i,
   output core_pkg::wb_data_t wb_dat_o,
   output logic               wb_ack_o,
   input  logic               pps_i,
   input  logic               cgen_st_status_i,
   input  logic               cgen_st_ld_i,
   input  logic               cgen_st_refmon_i,
   output logic               cgen_sync_b_o,
   output logic               cgen_ref_sel_o
);
   import core_pkg::*;

   logic [3:0] slave_sel;
   logic       bus_req;
   logic       stb_misc, stb_rb, stb_set;
   wb_data_t   misc_dat, rb_dat;
   logic       misc_ack, rb_ack, set_ack;

   logic       set_stb;
   set_addr_t  set_addr;
   set_data_t  set_data;
   vita_time_t vita_time, vita_time_pps;
   set_data_t  reg_test32;

   //////////////////////////////
   // Address decode and return path

   assign slave_sel = wb_adr_i[10:7];
   assign bus_req   = wb_cyc_i & wb_stb_i;
   assign stb_misc  = bus_req & (slave_sel == SLAVE_MISC);
   assign stb_rb    = bus_req & (slave_sel == SLAVE_READBACK);
   assign stb_set   = bus_req & slave_sel[3];    // Slaves 8 to 15

   always_comb
   begin
      wb_dat_o = '0;
      wb_ack_o = 1'b0;
      if (slave_sel[3])
         wb_ack_o = set_ack;                     // Settings reads give 0
      else
      begin
         case (slave_sel)
            SLAVE_MISC:
            begin
               wb_dat_o = misc_dat;
               wb_ack_o = misc_ack;
            end
            SLAVE_READBACK:
            begin
               wb_dat_o = rb_dat;
               wb_ack_o = rb_ack;
            end
            default: ;                           // Slaves 1 to 6 never ack
         endcase
      end
   end

   //////////////////////////////
   // Slaves and settings consumers

   settings_bus_16le u_settings (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .wb_stb_i(stb_set), .wb_we_i(wb_we_i), .wb_ack_o(set_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   vita_time_64 #(.BASE(TIME_BASE)) u_time (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

   misc_regs #(.TEST_ADDR(TEST_ADDR)) u_misc (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr_i[6:0]), .wb_dat_i(wb_dat_i),
      .wb_stb_i(stb_misc), .wb_we_i(wb_we_i), .wb_dat_o(misc_dat), .wb_ack_o(misc_ack),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i), .cgen_sync_b_o(cgen_sync_b_o),
      .cgen_ref_sel_o(cgen_ref_sel_o), .reg_test32_o(reg_test32));

   readback_mux u_readback (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr_i[5:1]), .wb_stb_i(stb_rb),
      .wb_dat_o(rb_dat), .wb_ack_o(rb_ack),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps), .reg_test32_i(reg_test32));

endmodule

// ==== dv/core_tb.sv ====
// Control core testbench

`timescale 1ns/10ps

module core_tb;
   import core_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int N_CTRL     = 30;
   localparam int N_STATUS   = 10;
   localparam int N_SET      = 10;
   // Bus cycles per test loop, plus the time load tests
   localparam int RUN_CYCLES = N_CTRL*8 + N_STATUS*2*4 + N_SET*12 + 200;

   logic      wb_clk;
   logic      wb_rst;
   wb_addr_t  wb_adr_i;
   wb_data_t  wb_dat_i;
   logic      wb_we_i;
   logic      wb_cyc_i;
   logic      wb_stb_i;
   wb_data_t  wb_dat_o;
   logic      wb_ack_o;
   logic      pps_i;
   logic      cgen_st_status_i;
   logic      cgen_st_ld_i;
   logic      cgen_st_refmon_i;
   logic      cgen_sync_b_o;
   logic      cgen_ref_sel_o;

   integer    seed = 2;
   int        cyc_cnt = 0;      // Free running cycle count
   int        last_accept;      // Count at the last accepted write

   wb_data_t  ctrl_model;
   wb_data_t  test_model;
   set_data_t test32_model;
   set_data_t compat_model;

   core_top #(.TIME_BASE(SR_TIME64), .TEST_ADDR(SR_REG_TEST32)) u_core_top (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .wb_we_i(wb_we_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .pps_i(pps_i),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i), .cgen_sync_b_o(cgen_sync_b_o),
      .cgen_ref_sel_o(cgen_ref_sel_o));

   initial
   begin
      wb_clk = 1'b0;
      forever #(CLK_PERIOD/2) wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk)
      cyc_cnt <= cyc_cnt + 1;

   initial
   begin
      #(2 * RUN_CYCLES * CLK_PERIOD);
      $display("Watchdog expired, a bus access or test step never completed");
      $display("RESULT: FAIL");
      $fatal(1, "Timeout");
   end

   //////////////////////////////
   // Address helpers

   function automatic wb_addr_t misc_addr(input logic [6:0] idx);
      return {SLAVE_MISC, idx};
   endfunction

   function automatic wb_addr_t settings_addr(input set_addr_t sa, input logic half);
      return {1'b1, sa, half, 1'b0};                 // Bit 10 picks the settings bus
   endfunction

   function automatic wb_addr_t readback_addr(input logic [3:0] word, input logic half);
      return {SLAVE_READBACK, 1'b0, word, half, 1'b0};
   endfunction

   //////////////////////////////
   // Bus access

   task automatic bus_write(input wb_addr_t adr, input wb_data_t dat);
      begin
         @(posedge wb_clk);
         wb_adr_i <= adr;
         wb_dat_i <= dat;
         wb_we_i  <= 1'b1;
         wb_cyc_i <= 1'b1;
         wb_stb_i <= 1'b1;
         @(negedge wb_clk);
         while (!wb_ack_o)
            @(negedge wb_clk);
         @(posedge wb_clk);                          // Write taken on this edge
         last_accept = cyc_cnt;
         wb_we_i  <= 1'b0;
         wb_cyc_i <= 1'b0;
         wb_stb_i <= 1'b0;
      end
   endtask

   task automatic bus_read(input wb_addr_t adr, output wb_data_t dat);
      begin
         @(posedge wb_clk);
         wb_adr_i <= adr;
         wb_we_i  <= 1'b0;
         wb_cyc_i <= 1'b1;
         wb_stb_i <= 1'b1;
         @(negedge wb_clk);
         while (!wb_ack_o)
            @(negedge wb_clk);
         dat = wb_dat_o;
         @(posedge wb_clk);
         wb_cyc_i <= 1'b0;
         wb_stb_i <= 1'b0;
      end
   endtask

   task automatic settings_write(input set_addr_t sa, input set_data_t d);
      begin
         bus_write(settings_addr(sa, 1'b0), d[15:0]);
         bus_write(settings_addr(sa, 1'b1), d[31:16]);
      end
   endtask

   task automatic read_word(input logic [3:0] word, output set_data_t w);
      wb_data_t lo;
      wb_data_t hi;
      begin
         bus_read(readback_addr(word, 1'b0), lo);    // Low half first
         bus_read(readback_addr(word, 1'b1), hi);
         w = {hi, lo};
      end
   endtask

   task automatic read_time(input logic [3:0] hi_word, output logic [63:0] t);
      set_data_t hi;
      set_data_t lo;
      begin
         read_word(hi_word, hi);
         read_word(hi_word + 4'd1, lo);
         t = {hi, lo};
      end
   endtask

   //////////////////////////////
   // Checks

   task automatic check_equal(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      begin
         assert (got === exp)
         else
         begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Value mismatch");
         end
      end
   endtask

   task automatic check_range(input string name, input logic [63:0] got,
                              input logic [63:0] lo, input logic [63:0] hi);
      begin
         assert (got >= lo && got <= hi)
         else
         begin
            $display("FAILED at %0t: %s is %h, expected %h to %h", $time, name, got, lo, hi);
            $display("RESULT: FAIL");
            $fatal(1, "Value out of range");
         end
      end
   endtask

   //////////////////////////////
   // Stimulus

   initial
   begin : main
      wb_data_t    rd;
      wb_data_t    dat;
      set_data_t   w;
      set_data_t   hi_rnd;
      set_data_t   lo_rnd;
      logic [6:0]  idx;
      logic [2:0]  st;
      logic [63:0] v;
      logic [63:0] t_now;
      logic [63:0] t_pre;
      logic [63:0] cap;
      int          start;

      wb_rst           = 1'b1;
      wb_adr_i         = '0;
      wb_dat_i         = '0;
      wb_we_i          = 1'b0;
      wb_cyc_i         = 1'b0;
      wb_stb_i         = 1'b0;
      pps_i            = 1'b0;
      cgen_st_status_i = 1'b0;
      cgen_st_ld_i     = 1'b0;
      cgen_st_refmon_i = 1'b0;
      ctrl_model       = 16'd3;                      // Sync high, ref select high
      test_model       = 16'd0;
      compat_model     = {16'd10, 16'd2};
      repeat (2) @(posedge wb_clk);
      wb_rst <= 1'b0;

      // Control and test registers
      @(negedge wb_clk);
      check_equal("cgen_sync_b_o", cgen_sync_b_o, 1'b1);
      check_equal("cgen_ref_sel_o", cgen_ref_sel_o, 1'b1);
      for (int i = 0; i < N_CTRL; i++)
      begin
         dat = $random(seed);
         if ($random(seed) & 1)
         begin
            bus_write(misc_addr(REG_CGEN_CTRL), dat);
            ctrl_model = dat;
         end
         else
         begin
            bus_write(misc_addr(REG_TEST), dat);
            test_model = dat;
         end
         bus_read(misc_addr(REG_CGEN_CTRL), rd);
         check_equal("wb_dat_o", rd, ctrl_model);
         bus_read(misc_addr(REG_TEST), rd);
         check_equal("wb_dat_o", rd, test_model);
         @(negedge wb_clk);
         check_equal("cgen_sync_b_o", cgen_sync_b_o, ctrl_model[1]);
         check_equal("cgen_ref_sel_o", cgen_ref_sel_o, ctrl_model[0]);
      end

      // Status readback and unmapped indices
      for (int i = 0; i < N_STATUS; i++)
      begin
         st = $random(seed);
         @(posedge wb_clk);
         {cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i} <= st;
         bus_read(misc_addr(REG_CGEN_ST), rd);
         check_equal("wb_dat_o", rd, {13'd0, st});
      end
      for (int i = 0; i < N_STATUS; i++)
      begin
         do
            idx = $random(seed);
         while (idx == 7'd4 || idx == 7'd6 || idx == 7'd8);
         bus_read(misc_addr(idx), rd);
         check_equal("wb_dat_o", rd, 16'hBEEF);
      end

      // Test setting through the settings bus
      for (int i = 0; i < N_SET; i++)
      begin
         w = $random(seed);
         settings_write(SR_REG_TEST32, w);
         test32_model = w;
         read_word(4'd4, w);
         check_equal("reg_test32", w, test32_model);
      end
      bus_write(settings_addr(SR_REG_TEST32, 1'b1), $random(seed));   // Lone high half
      read_word(4'd4, w);
      check_equal("reg_test32", w, test32_model);
      read_word(4'd6, w);
      check_equal("compat_num", w, compat_model);

      // Immediate time load with small low bits so reads see no carry
      hi_rnd = $random(seed) & 32'h7FFF_FFFF;
      lo_rnd = $random(seed) & 32'hFFFF_0FFF;
      v = {hi_rnd, lo_rnd};
      settings_write(SR_TIME64, v[63:32]);
      settings_write(SR_TIME64 + 8'd1, v[31:0]);
      settings_write(SR_TIME64 + 8'd2, 32'd1);
      start = last_accept;
      read_time(4'd0, t_now);
      check_range("vita_time", t_now, v, v + (cyc_cnt - start));

      // Load armed for the next PPS
      lo_rnd = $random(seed) & 32'h0000_0FFF;
      v = ((t_now + 64'h0000_0100_0000_0000) & ~64'hFFFF) | lo_rnd;
      settings_write(SR_TIME64, v[63:32]);
      settings_write(SR_TIME64 + 8'd1, v[31:0]);
      settings_write(SR_TIME64 + 8'd2, 32'd0);
      read_time(4'd0, t_pre);
      check_range("vita_time", t_pre, t_now, v - 64'd1);
      @(posedge wb_clk);
      pps_i <= 1'b1;
      start = cyc_cnt;
      repeat (4) @(posedge wb_clk);
      pps_i <= 1'b0;
      read_time(4'd0, t_now);
      check_range("vita_time", t_now, v, v + (cyc_cnt - start));
      // Capture holds the count from before the armed load
      read_time(4'd2, cap);
      check_range("vita_time_pps", cap, t_pre, v - 64'd1);

      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== all.f ====
common/core_pkg.sv
settings/settings_bus_16le.sv
timing/vita_time_64.sv
design/misc_regs.sv
design/readback_mux.sv
design/core_top.sv
dv/core_tb.sv

// ==== Bender.yml ====
package:
  name: radio_ctrl_core

sources:
  - files:
      - common/core_pkg.sv
      - settings/settings_bus_16le.sv
      - timing/vita_time_64.sv
      - design/misc_regs.sv
      - design/readback_mux.sv
      - design/core_top.sv
  - target: test
    files:
      - dv/core_tb.sv
